// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := operand_entry_tb
FILE_LIST := verilog.f
OBJ_DIR   := obj_dir
SIM_ARGS  := +verilator+error+limit+1000
PASS_TEXT := STATUS: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: button_input/button_debounce.sv
`default_nettype none

module button_debounce #(
    parameter int TICK_DIVISOR = 50_000_000
) (
    input  logic                     clk,
    input  logic                     reset,
    input  entry_pkg::button_press_t buttons,
    output entry_pkg::button_press_t presses
);
    import entry_pkg::*;

    localparam int COUNT_WIDTH = (TICK_DIVISOR > 1) ? $clog2(TICK_DIVISOR) : 1;
    localparam logic [COUNT_WIDTH-1:0] TICK_LAST = COUNT_WIDTH'(TICK_DIVISOR - 1);

    logic [COUNT_WIDTH-1:0] tick_count;
    logic                   tick;
    logic                   sampled;     // Samples are fresh this cycle
    button_press_t          sample_new;
    button_press_t          sample_old;

    //////////////////////////////
    // Sample tick
    //////////////////////////////

    assign tick = (tick_count == TICK_LAST);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tick_count <= '0;
        end else if (tick) begin
            tick_count <= '0;
        end else begin
            tick_count <= tick_count + 1'b1;
        end
    end

    //////////////////////////////
    // Two-stage sampling
    //////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sample_new <= '0;
            sample_old <= '0;
            sampled    <= 1'b0;
        end else begin
            sampled <= tick;
            if (tick) begin
                sample_new <= buttons;
                sample_old <= sample_new;
            end
        end
    end

    // Rising edge between the last two samples, held for one clk only
    always_comb begin
        if (sampled) begin
            presses = button_press_t'(sample_new & ~sample_old);
        end else begin
            presses = '0;
        end
    end

endmodule

`default_nettype wire

// File: button_input/operand_editor.sv
`default_nettype none

module operand_editor (
    input  logic                      clk,
    input  logic                      reset,
    input  entry_pkg::button_press_t  presses,
    output entry_pkg::operand_write_t store_write,
    output entry_pkg::operand_sel_t   selected,
    output entry_pkg::digit_place_t   cursor
);
    import entry_pkg::*;

    operand_t            working [2];  // Working copies of A and B
    operand_t            current;
    logic signed [11:0]  step;         // Power of ten at the cursor
    logic signed [11:0]  raised;
    logic signed [11:0]  lowered;
    logic                up_ok;
    logic                down_ok;
    digit_place_t        cursor_higher;
    digit_place_t        cursor_lower;

    //////////////////////////////
    // Edit candidates
    //////////////////////////////

    assign current = working[selected];

    always_comb begin
        case (cursor)
            PLACE_TENS:     step = 12'sd10;
            PLACE_HUNDREDS: step = 12'sd100;
            default:        step = 12'sd1;
        endcase
    end

    // 12-bit sums so 999 + 100 cannot wrap
    assign raised  = current + step;
    assign lowered = current - step;
    assign up_ok   = (raised <= OPERAND_MAX);
    assign down_ok = (lowered >= OPERAND_MIN);

    always_comb begin
        case (cursor)
            PLACE_ONES: begin
                cursor_higher = PLACE_TENS;
                cursor_lower  = PLACE_HUNDREDS;  // Wrap from ones
            end
            PLACE_TENS: begin
                cursor_higher = PLACE_HUNDREDS;
                cursor_lower  = PLACE_ONES;
            end
            default: begin
                cursor_higher = PLACE_ONES;      // Wrap from hundreds
                cursor_lower  = PLACE_TENS;
            end
        endcase
    end

    //////////////////////////////
    // Registered state
    //////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            working[OPERAND_A] <= '0;
            working[OPERAND_B] <= '0;
            selected           <= OPERAND_A;
            cursor             <= PLACE_ONES;
            store_write        <= '0;
        end else begin
            store_write.valid <= 1'b0;  // Strobe, default low
            // One press per cycle, centre first
            if (presses.centre) begin
                selected <= (selected == OPERAND_A) ? OPERAND_B : OPERAND_A;
            end else if (presses.left) begin
                cursor <= cursor_higher;
            end else if (presses.right) begin
                cursor <= cursor_lower;
            end else if (presses.up) begin
                if (up_ok) begin
                    working[selected] <= raised[10:0];
                    store_write.valid <= 1'b1;
                    store_write.addr  <= selected;
                    store_write.data  <= raised[10:0];
                end
            end else if (presses.down) begin
                if (down_ok) begin
                    working[selected] <= lowered[10:0];
                    store_write.valid <= 1'b1;
                    store_write.addr  <= selected;
                    store_write.data  <= lowered[10:0];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: common/entry_pkg.sv
`default_nettype none

package entry_pkg;

    //////////////////////////////
    // Operand values
    //////////////////////////////

    typedef logic signed [10:0] operand_t;  // Holds -999..+999 with headroom

    localparam operand_t OPERAND_MAX = 11'sd999;
    localparam operand_t OPERAND_MIN = -11'sd999;

    typedef enum logic {
        OPERAND_A,
        OPERAND_B
    } operand_sel_t;  // Edit target and store address

    typedef enum logic [1:0] {
        PLACE_ONES,
        PLACE_TENS,
        PLACE_HUNDREDS
    } digit_place_t;

    //////////////////////////////
    // Bundles between blocks
    //////////////////////////////

    // One-cycle press pulses, or raw levels at the pins
    typedef struct packed {
        logic centre;
        logic up;
        logic left;
        logic right;
        logic down;
    } button_press_t;

    typedef struct packed {
        logic         valid;
        operand_sel_t addr;
        operand_t     data;
    } operand_write_t;

    typedef struct packed {
        logic         negative;
        logic [3:0]   hundreds;
        logic [3:0]   tens;
        logic [3:0]   ones;
        digit_place_t cursor;
        operand_sel_t selected;
    } display_t;

endpackage

`default_nettype wire

// File: source/display_formatter.sv
`default_nettype none

module display_formatter (
    input  logic                    clk,
    input  logic                    reset,
    input  entry_pkg::operand_t     operand,
    input  entry_pkg::operand_sel_t selected,
    input  entry_pkg::digit_place_t cursor,
    output entry_pkg::display_t     display
);
    import entry_pkg::*;

    logic       negative;
    logic [9:0] magnitude;  // Up to 999
    logic [9:0] tens_part;
    logic [3:0] hundreds_digit;
    logic [3:0] tens_digit;
    logic [3:0] ones_digit;

    //////////////////////////////
    // Sign and magnitude
    //////////////////////////////

    assign negative = operand[10];

    always_comb begin
        if (negative) begin
            magnitude = 10'(-operand);
        end else begin
            magnitude = 10'(operand);
        end
    end

    //////////////////////////////
    // Decimal split
    //////////////////////////////

    assign hundreds_digit = 4'(magnitude / 10'd100);
    assign tens_part      = magnitude % 10'd100;  // Below 100
    assign tens_digit     = 4'(tens_part / 10'd10);
    assign ones_digit     = 4'(tens_part % 10'd10);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            display <= '0;  // Positive 000, ones, operand A
        end else begin
            display.negative <= negative;
            display.hundreds <= hundreds_digit;
            display.tens     <= tens_digit;
            display.ones     <= ones_digit;
            display.cursor   <= cursor;
            display.selected <= selected;
        end
    end

endmodule

`default_nettype wire

// File: source/operand_entry_top.sv
`default_nettype none

module operand_entry_top #(
    parameter int TICK_DIVISOR = 50_000_000  // One sample every 0.5 s at 100 MHz
) (
    input  logic                     clk,
    input  logic                     reset,
    input  entry_pkg::button_press_t buttons,
    output entry_pkg::display_t      display
);
    import entry_pkg::*;

    button_press_t  presses;
    operand_write_t store_write;
    operand_sel_t   selected;
    digit_place_t   cursor;
    operand_t       read_data;

    button_debounce #(
        .TICK_DIVISOR(TICK_DIVISOR)
    ) button_debounce_inst (
        .clk    (clk),
        .reset  (reset),
        .buttons(buttons),
        .presses(presses)
    );

    operand_editor operand_editor_inst (
        .clk        (clk),
        .reset      (reset),
        .presses    (presses),
        .store_write(store_write),
        .selected   (selected),
        .cursor     (cursor)
    );

    operand_store operand_store_inst (
        .clk        (clk),
        .reset      (reset),
        .store_write(store_write),
        .read_sel   (selected),
        .read_data  (read_data)
    );

    display_formatter display_formatter_inst (
        .clk     (clk),
        .reset   (reset),
        .operand (read_data),
        .selected(selected),
        .cursor  (cursor),
        .display (display)
    );

endmodule

`default_nettype wire

// File: source/operand_store.sv
`default_nettype none

module operand_store (
    input  logic                      clk,
    input  logic                      reset,
    input  entry_pkg::operand_write_t store_write,
    input  entry_pkg::operand_sel_t   read_sel,
    output entry_pkg::operand_t       read_data
);
    import entry_pkg::*;

    operand_t words [2];  // Word 0 is A, word 1 is B

    //////////////////////////////
    // Write port
    //////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            words[OPERAND_A] <= '0;
            words[OPERAND_B] <= '0;
        end else if (store_write.valid) begin
            words[store_write.addr] <= store_write.data;
        end
    end

    //////////////////////////////
    // Read port
    //////////////////////////////

    // Combinational, so the formatter sees a write on the next cycle
    assign read_data = words[read_sel];

endmodule

`default_nettype wire

// File: verification/operand_entry_assert.sv
`default_nettype none

module operand_entry_assert (
    input logic                     clk,
    input logic                     reset,
    input entry_pkg::button_press_t presses,
    input logic                     write_valid,
    input entry_pkg::operand_t      value_a,
    input entry_pkg::operand_t      value_b,
    input entry_pkg::display_t      display
);
    timeunit 1ns;
    timeprecision 1ps;
    import entry_pkg::*;

    int failure_count = 0;

    // A store write follows a press by exactly one cycle
    write_after_press: assert property (
        @(posedge clk) disable iff (reset) write_valid |-> $past(presses != '0)
    ) else begin
        failure_count++;
        $error("store write with no press in the previous cycle");
    end

    decimal_digits: assert property (
        @(posedge clk) disable iff (reset)
        (display.hundreds <= 4'd9) && (display.tens <= 4'd9) && (display.ones <= 4'd9)
    ) else begin
        failure_count++;
        $error("display digit above 9");
    end

    operand_range: assert property (
        @(posedge clk) disable iff (reset)
        (value_a >= OPERAND_MIN) && (value_a <= OPERAND_MAX) &&
        (value_b >= OPERAND_MIN) && (value_b <= OPERAND_MAX)
    ) else begin
        failure_count++;
        $error("operand outside -999..999");
    end

endmodule

////////////////////////////////
// Attachments
////////////////////////////////

bind operand_editor operand_entry_assert editor_checks (
    .clk(clk), .reset(reset), .presses(presses),
    .write_valid(store_write.valid),
    .value_a(working[0]), .value_b(working[1]),  // Both working copies
    .display('0)
);

bind display_formatter operand_entry_assert formatter_checks (
    .clk(clk), .reset(reset), .presses('0),
    .write_valid(1'b0),
    .value_a(operand), .value_b(operand),  // Stored value of the selection
    .display(display)
);

`default_nettype wire

// File: verification/operand_entry_tb.sv
`default_nettype none

module operand_entry_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import entry_pkg::*;

    localparam int TICK_DIVISOR     = 4;
    localparam int RESET_CYCLES     = 16;
    localparam int HOLD_CYCLES      = 3 * TICK_DIVISOR;  // Three sample ticks
    localparam int PRESS_CYCLES     = 2 * HOLD_CYCLES + 1;
    localparam int DIRECTED_PRESSES = 9 + 5 + 30 + 4;
    localparam int RANDOM_PRESSES   = 40;
    localparam int CYCLE_LIMIT      =
        2 * (RESET_CYCLES + 2 + (DIRECTED_PRESSES + RANDOM_PRESSES) * PRESS_CYCLES);

    localparam button_press_t BTN_CENTRE = button_press_t'(5'b10000);
    localparam button_press_t BTN_UP     = button_press_t'(5'b01000);
    localparam button_press_t BTN_LEFT   = button_press_t'(5'b00100);
    localparam button_press_t BTN_RIGHT  = button_press_t'(5'b00010);
    localparam button_press_t BTN_DOWN   = button_press_t'(5'b00001);

    logic          clk;
    logic          reset;
    button_press_t buttons;
    display_t      display;

    int           model_value [2];  // Reference copies of A and B
    operand_sel_t model_sel;
    digit_place_t model_cursor;
    int unsigned  cycle_count = 0;

    operand_entry_top #(
        .TICK_DIVISOR(TICK_DIVISOR)
    ) operand_entry_top_inst (
        .clk    (clk),
        .reset  (reset),
        .buttons(buttons),
        .display(display)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////
    // Failure handling
    ////////////////////////////////

    function automatic int assertion_failures();
        return operand_entry_top_inst.operand_editor_inst.editor_checks.failure_count +
               operand_entry_top_inst.display_formatter_inst.formatter_checks.failure_count;
    endfunction

    task automatic stop_with_failure();
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (assertion_failures() != 0) begin
            $display("A bound assertion failed near cycle %0d", cycle_count);
            stop_with_failure();
        end else if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
            stop_with_failure();
        end
    end

    task automatic check_display(input display_t actual, input display_t expected);
        if (actual !== expected) begin
            $display("[ERROR] display: got %h, expected %h", actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_selected(input operand_sel_t actual, input operand_sel_t expected);
        if (actual !== expected) begin
            $display("[ERROR] display.selected: got %h, expected %h", actual, expected);
            stop_with_failure();
        end
    endtask

    ////////////////////////////////
    // Reference model
    ////////////////////////////////

    function automatic void apply_model(input button_press_t press);
        int step;
        int next_value;
        step = (model_cursor == PLACE_HUNDREDS) ? 100 : (model_cursor == PLACE_TENS) ? 10 : 1;
        if (press.centre) begin
            model_sel = (model_sel == OPERAND_A) ? OPERAND_B : OPERAND_A;
        end else if (press.left) begin  // Towards hundreds, then back to ones
            model_cursor = (model_cursor == PLACE_ONES) ? PLACE_TENS :
                           (model_cursor == PLACE_TENS) ? PLACE_HUNDREDS : PLACE_ONES;
        end else if (press.right) begin
            model_cursor = (model_cursor == PLACE_HUNDREDS) ? PLACE_TENS :
                           (model_cursor == PLACE_TENS) ? PLACE_ONES : PLACE_HUNDREDS;
        end else if (press.up || press.down) begin
            next_value = model_value[model_sel] + (press.up ? step : -step);
            if (next_value >= -999 && next_value <= 999) begin
                model_value[model_sel] = next_value;
            end
        end
    endfunction

    function automatic display_t expected_display();
        display_t expected;
        int       value;
        int       magnitude;
        value = model_value[model_sel];
        magnitude = (value < 0) ? -value : value;
        expected.negative = (value < 0);
        expected.hundreds = 4'(magnitude / 100);
        expected.tens     = 4'((magnitude / 10) % 10);
        expected.ones     = 4'(magnitude % 10);
        expected.cursor   = model_cursor;
        expected.selected = model_sel;
        return expected;
    endfunction

    ////////////////////////////////
    // Stimulus
    ////////////////////////////////

    task automatic press_button(input button_press_t press);
        @(posedge clk);
        #2 buttons = press;
        repeat (HOLD_CYCLES) @(posedge clk);
        #2 buttons = '0;
        repeat (HOLD_CYCLES) @(posedge clk);
        #2;
    endtask

    task automatic press_and_check(input button_press_t press);
        press_button(press);
        apply_model(press);
        check_selected(display.selected, model_sel);
        check_display(display, expected_display());
    endtask

    task automatic test_reset_state();
        check_display(display, '{1'b0, 4'd0, 4'd0, 4'd0, PLACE_ONES, OPERAND_A});
    endtask

    task automatic test_build_value();
        press_and_check(BTN_UP);
        press_and_check(BTN_LEFT);
        repeat (2) press_and_check(BTN_UP);
        press_and_check(BTN_LEFT);
        repeat (3) press_and_check(BTN_UP);
        press_and_check(BTN_LEFT);  // Hundreds wraps to ones
        check_display(display, '{1'b0, 4'd3, 4'd2, 4'd1, PLACE_ONES, OPERAND_A});
    endtask

    task automatic test_go_negative();
        press_and_check(BTN_RIGHT);  // Ones wraps to hundreds
        repeat (4) press_and_check(BTN_DOWN);
        check_display(display, '{1'b1, 4'd0, 4'd7, 4'd9, PLACE_HUNDREDS, OPERAND_A});
    endtask

    task automatic test_range_limits();
        repeat (10) press_and_check(BTN_DOWN);  // Last one would reach -1079
        check_display(display, '{1'b1, 4'd9, 4'd7, 4'd9, PLACE_HUNDREDS, OPERAND_A});
        repeat (20) press_and_check(BTN_UP);    // Last one would reach 1021
        check_display(display, '{1'b0, 4'd9, 4'd2, 4'd1, PLACE_HUNDREDS, OPERAND_A});
    endtask

    task automatic test_switch_operand();
        press_and_check(BTN_CENTRE);
        repeat (2) press_and_check(BTN_UP);
        check_display(display, '{1'b0, 4'd2, 4'd0, 4'd0, PLACE_HUNDREDS, OPERAND_B});
        press_and_check(BTN_CENTRE);
        check_display(display, '{1'b0, 4'd9, 4'd2, 4'd1, PLACE_HUNDREDS, OPERAND_A});
    endtask

    task automatic test_random_presses();
        button_press_t press;
        repeat (RANDOM_PRESSES) begin
            press = button_press_t'(5'b00001 << $urandom_range(4, 0));
            press_and_check(press);
        end
    endtask

    initial begin
        void'($urandom(32'h4f53));
        reset = 1'b1;
        buttons = '0;
        model_value[0] = 0;
        model_value[1] = 0;
        model_sel = OPERAND_A;
        model_cursor = PLACE_ONES;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 reset = 1'b0;
        @(posedge clk);
        #2;
        test_reset_state();
        test_build_value();
        test_go_negative();
        test_range_limits();
        test_switch_operand();
        test_random_presses();
        if (assertion_failures() == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("A bound assertion failed before the end of the run");
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire

// File: verilog.f
common/entry_pkg.sv
button_input/button_debounce.sv
button_input/operand_editor.sv
source/operand_store.sv
source/display_formatter.sv
source/operand_entry_top.sv
verification/operand_entry_assert.sv
verification/operand_entry_tb.sv
